// ==== flist.f ====
+incdir+source
source/opl3_pkg.sv
source/clk_div.sv
source/tone_regs.sv
source/phase_gen.sv
source/operator_out.sv
source/i2s_tx.sv
source/opl3_tone_top.sv
bench/opl3_tone_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= opl3_tone_tb
FLIST     ?= flist.f
PASS_MSG  := Finished with no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== bench/opl3_tone_tb.sv ====
/*
  Table-driven testbench for the FM tone slice. It rebuilds I2S frames from
  sclk/ws/sd and checks them against a phase model stepped once per frame.
  Runs at FRAME_CLKS = 128 with a 100 ns clock.
*/
`timescale 1ns/100ps
`default_nettype none

module opl3_tone_tb
    import opl3_pkg::*;
;
    localparam int CLK_FREQ    = 6144000;
    localparam int SAMPLE_FREQ = 48000;
    localparam int NUM_TESTS   = 8;
    localparam int HALF_PHASE  = 2**(PHASE_WIDTH-1);

    typedef struct {
        int fnum;
        int mult;
        int block;
        int env;
        int key;
        int frames;
        int rnd;
        int cmp_prev;
    } test_t;

    logic       clk;
    logic       rst_n;
    logic       req;
    reg_write_t wr;
    wire        ack;
    wire        sclk;
    wire        ws;
    wire        sd;

    test_t  tests [NUM_TESTS];
    int     left_q[$];
    int     right_q[$];
    int     prev_mag[$];
    int     errors;
    integer seed;

    opl3_tone_top #(
        .CLK_FREQ   (CLK_FREQ),
        .SAMPLE_FREQ(SAMPLE_FREQ)
    ) i_opl3_tone_top (
        .clk  (clk),
        .rst_n(rst_n),
        .req  (req),
        .wr   (wr),
        .ack  (ack),
        .sclk (sclk),
        .ws   (ws),
        .sd   (sd)
    );

    always #50 clk = ~clk;

    // the I2S receiver takes bit slot k on rising edge k of sclk after a ws edge
    int             bit_pos = -1;
    logic           ws_seen = 1'b0;
    logic [15:0]    left_word;
    logic [15:0]    right_word;

    always @(posedge sclk) begin
        if (ws != ws_seen) begin
            ws_seen = ws;
            bit_pos = 0;
        end else begin
            bit_pos = bit_pos + 1;
        end
        if (bit_pos >= 1 && bit_pos <= SAMPLE_WIDTH) begin
            if (ws)
                right_word = {right_word[14:0], sd};
            else
                left_word = {left_word[14:0], sd};
        end
        if (ws && bit_pos == SAMPLE_WIDTH) begin
            left_q.push_back(int'($signed(left_word)));
            right_q.push_back(int'($signed(right_word)));
        end
    end

    // each ws level lasts half a frame of 64 clock cycles
    time last_ws_edge = 0;

    always @(ws) begin
        if (rst_n === 1'b1) begin
            if (last_ws_edge != 0) begin
                assert ($time - last_ws_edge == 64 * 100) else begin
                    $display("CHECK FAILED t=%0t ws half period expected %0d got %0d",
                             $time, 64 * 100, $time - last_ws_edge);
                    errors++;
                end
            end
            last_ws_edge = $time;
        end
    end

    task automatic write_reg(input reg_addr_t addr, input int value);
        int waited;
        @(posedge clk);
        wr  <= '{addr: addr, data: REG_DATA_WIDTH'(value)};
        req <= 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!ack && waited < 8);
        assert (ack) else begin
            $display("ERROR: no ack within 8 cycles of req for register %s",
                     addr.name());
            errors++;
        end
        @(posedge clk);
        req <= 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (ack && waited < 8);
        assert (!ack) else begin
            $display("ERROR: ack still high 8 cycles after req dropped");
            errors++;
        end
    endtask

    // the phase step is (fnum * mult) << block >> 1 where mult 0 counts as one half
    function automatic longint phase_step(input int fnum, input int mult, input int block);
        if (mult == 0)
            return (longint'(fnum) << block) >> 2;
        return (longint'(fnum) * mult << block) >> 1;
    endfunction

    // zero where the folded table index lands on its zero entry
    function automatic bit near_zero(input logic [PHASE_WIDTH-1:0] p);
        return (p[18:12] == 7'h00) || (p[18:12] == 7'h7f);
    endfunction

    function automatic int magnitude(input int v);
        return (v < 0) ? -v : v;
    endfunction

    // watchdog sized from the frame counts in the table
    initial begin
        longint limit;
        #1;
        limit = 200000;
        for (int t = 0; t < NUM_TESTS; t++)
            limit += longint'(tests[t].frames + 4) * 128 * 2 * 100;
        #(limit);
        $display("ERROR: timeout, the tone did not deliver the expected frames");
        $display("Finished with errors");
        $finish;
    end

    initial begin
        test_t                  tc;
        longint                 step;
        logic [PHASE_WIDTH-1:0] p;
        logic [PHASE_WIDTH-1:0] q;
        int                     base;
        int                     start_errors;
        int                     l;
        int                     r;
        int                     mags[$];

        clk    = 1'b0;
        rst_n  = 1'b0;
        req    = 1'b0;
        wr     = '0;
        errors = 0;
        seed   = 32'h9c95;

        // fnum, mult, block, env, key, frames, random, compare with previous
        tests[0] = '{300, 1, 4, 0, 0, 8, 0, 0};
        tests[1] = '{300, 1, 4, 511, 1, 8, 0, 0};
        tests[2] = '{512, 1, 7, 0, 1, 40, 0, 0};
        tests[3] = '{512, 1, 7, 300, 1, 40, 0, 1};
        tests[4] = '{400, 0, 7, 0, 1, 24, 0, 0};
        tests[5] = '{400, 1, 7, 0, 1, 24, 0, 0};
        tests[6] = '{0, 0, 0, 0, 1, 24, 1, 0};
        tests[7] = '{0, 0, 0, 100, 1, 24, 1, 0};

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        for (int t = 0; t < NUM_TESTS; t++) begin
            tc = tests[t];
            start_errors = errors;
            if (tc.rnd != 0) begin
                tc.fnum  = $random(seed) & 32'h3ff;
                tc.mult  = $random(seed) & 32'hf;
                tc.block = $random(seed) & 32'h7;
            end
            step = phase_step(tc.fnum, tc.mult, tc.block);

            write_reg(REG_KEY, 0);
            write_reg(REG_FNUM, tc.fnum);
            write_reg(REG_MULT, tc.mult);
            write_reg(REG_BLOCK, tc.block);
            write_reg(REG_ENV, tc.env);
            repeat (2) @(negedge ws);
            // the frame starting here still holds phase 0
            base = left_q.size();
            write_reg(REG_KEY, tc.key);
            while (left_q.size() < base + 1 + tc.frames)
                @(posedge clk);

            mags.delete();
            for (int n = 1; n <= tc.frames; n++) begin
                l = left_q[base + n];
                r = right_q[base + n];
                p = PHASE_WIDTH'(longint'(n) * step);
                mags.push_back(magnitude(l));
                assert (l == r) else begin
                    $display("CHECK FAILED t=%0t right expected %0d got %0d", $time, l, r);
                    errors++;
                end
                if (tc.key == 0 || tc.env == 511) begin
                    assert (l == 0) else begin
                        $display("CHECK FAILED t=%0t left expected %0d got %0d", $time, 0, l);
                        errors++;
                    end
                end else if (near_zero(p)) begin
                    assert (l == 0) else begin
                        $display("CHECK FAILED t=%0t left expected %0d got %0d", $time, 0, l);
                        errors++;
                    end
                end else begin
                    assert ((l < 0) == p[PHASE_WIDTH-1] && l != 0) else begin
                        $display("CHECK FAILED t=%0t left sign expected %0d got %0d",
                                 $time, p[PHASE_WIDTH-1], l < 0);
                        errors++;
                    end
                end
                if (tc.cmp_prev != 0 && n <= prev_mag.size()) begin
                    assert (magnitude(l) <= prev_mag[n-1] + 1) else begin
                        $display("CHECK FAILED t=%0t magnitude expected <= %0d got %0d",
                                 $time, prev_mag[n-1] + 1, magnitude(l));
                        errors++;
                    end
                end
            end

            // frames half a period apart must be negatives of each other
            for (int i = 1; i <= tc.frames; i++) begin
                for (int j = i + 1; j <= tc.frames; j++) begin
                    p = PHASE_WIDTH'(longint'(i) * step);
                    q = PHASE_WIDTH'(longint'(j) * step);
                    if (PHASE_WIDTH'(q - p) == PHASE_WIDTH'(HALF_PHASE)) begin
                        assert (left_q[base + j] == -left_q[base + i]) else begin
                            $display("CHECK FAILED t=%0t left expected %0d got %0d",
                                     $time, -left_q[base + i], left_q[base + j]);
                            errors++;
                        end
                    end
                end
            end
            prev_mag = mags;

            if (errors == start_errors)
                $display("test %0d fnum %0d mult %0d block %0d env %0d key %0d passed",
                         t, tc.fnum, tc.mult, tc.block, tc.env, tc.key);
            else
                $display("test %0d fnum %0d mult %0d block %0d env %0d key %0d failed",
                         t, tc.fnum, tc.mult, tc.block, tc.env, tc.key);
        end

        $display("tests run %0d, errors %0d", NUM_TESTS, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/opl3_tone_top.sv ====
/*
  Single FM voice: register port, phase accumulator, sine operator, I2S out.
  CLK_FREQ / SAMPLE_FREQ sets the I2S frame length and must suit i2s_tx.
*/
`timescale 1ns/100ps
`default_nettype none

module opl3_tone_top
    import opl3_pkg::*;
#(
    parameter int CLK_FREQ    = 12288000,
    parameter int SAMPLE_FREQ = 48000
) (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        req,
    input  reg_write_t wr,
    output logic       ack,
    output logic       sclk,
    output logic       ws,
    output logic       sd
);
    localparam int FRAME_CLKS = CLK_FREQ / SAMPLE_FREQ;

    logic                           sample_en;
    voice_t                         voice;
    logic        [PHASE_WIDTH-1:0]  phase;
    logic                           phase_valid;
    logic signed [SAMPLE_WIDTH-1:0] sample;
    logic                           sample_valid;

    clk_div #(
        .INPUT_CLK_FREQ    (CLK_FREQ),
        .OUTPUT_CLK_EN_FREQ(SAMPLE_FREQ)
    ) i_clk_div (
        .clk   (clk),
        .rst_n (rst_n),
        .clk_en(sample_en)
    );

    tone_regs i_tone_regs (
        .clk  (clk),
        .rst_n(rst_n),
        .req  (req),
        .wr   (wr),
        .ack  (ack),
        .voice(voice)
    );

    phase_gen i_phase_gen (
        .clk        (clk),
        .rst_n      (rst_n),
        .sample_en  (sample_en),
        .voice      (voice),
        .phase      (phase),
        .phase_valid(phase_valid)
    );

    operator_out i_operator_out (
        .clk         (clk),
        .rst_n       (rst_n),
        .phase_en    (phase_valid),
        .phase       (phase),
        .env         (voice.env),
        .sample      (sample),
        .sample_valid(sample_valid)
    );

    i2s_tx #(
        .FRAME_CLKS(FRAME_CLKS)
    ) i_i2s_tx (
        .clk         (clk),
        .rst_n       (rst_n),
        .sample      (sample),
        .sample_valid(sample_valid),
        .sclk        (sclk),
        .ws          (ws),
        .sd          (sd)
    );

endmodule

`default_nettype wire

// ==== source/i2s_tx.sv ====
/*
  I2S sender, sclk = clk/2, same sample on left and right. FRAME_CLKS must be
  a multiple of 4 and at least 4 * (SAMPLE_WIDTH + 1) so a word fits its slot.
  Without a new sample_valid the frame ends and all outputs go low.
*/
`timescale 1ns/100ps
`default_nettype none

module i2s_tx
    import opl3_pkg::*;
#(
    parameter int FRAME_CLKS = 256
) (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire signed [SAMPLE_WIDTH-1:0] sample,
    input  wire                           sample_valid,
    output logic                          sclk,
    output logic                          ws,
    output logic                          sd
);
    localparam int HALF_CLKS  = FRAME_CLKS / 2;
    localparam int CNT_WIDTH  = $clog2(FRAME_CLKS);
    localparam int WORD_WIDTH = 2 * SAMPLE_WIDTH;

    logic [CNT_WIDTH-1:0]  cnt;
    logic [CNT_WIDTH-1:0]  cnt_next;
    logic [CNT_WIDTH-1:0]  slot_cnt;
    logic [CNT_WIDTH-2:0]  bit_idx;
    logic                  active;
    logic                  active_next;
    logic                  right_next;
    logic                  data_slot;
    logic [WORD_WIDTH-1:0] shreg;

    always_comb begin
        cnt_next    = cnt;
        active_next = active;
        if (sample_valid) begin
            cnt_next    = '0;
            active_next = 1'b1;
        end else if (active && cnt == CNT_WIDTH'(FRAME_CLKS - 1)) begin
            cnt_next    = '0;
            active_next = 1'b0;
        end else if (active) begin
            cnt_next = cnt + 1'b1;
        end
        right_next = (cnt_next >= CNT_WIDTH'(HALF_CLKS));
        slot_cnt   = right_next ? cnt_next - CNT_WIDTH'(HALF_CLKS) : cnt_next;
        // data occupies sclk periods 1 to SAMPLE_WIDTH after each ws edge
        bit_idx    = slot_cnt[CNT_WIDTH-1:1];
        data_slot  = active_next && (bit_idx != '0) &&
                     (bit_idx <= (CNT_WIDTH-1)'(SAMPLE_WIDTH));
    end

    // even counts are the falling edge of sclk, where sd and ws move
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt    <= '0;
            active <= 1'b0;
            sclk   <= 1'b0;
            ws     <= 1'b0;
            sd     <= 1'b0;
        end else begin
            cnt    <= cnt_next;
            active <= active_next;
            sclk   <= active_next & cnt_next[0];
            ws     <= active_next & right_next;
            if (!cnt_next[0])
                sd <= data_slot & shreg[WORD_WIDTH-1];
        end
    end

    always_ff @(posedge clk) begin
        if (sample_valid)
            shreg <= {sample, sample};
        else if (data_slot && !cnt_next[0])
            shreg <= shreg << 1;
    end

endmodule

`default_nettype wire

// ==== source/operator_out.sv ====
/*
  Sine lookup and linear attenuation, two cycles from phase_en to
  sample_valid. A new phase may be presented on every cycle.
*/
`timescale 1ns/100ps
`default_nettype none

module operator_out
    import opl3_pkg::*;
(
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            phase_en,
    input  wire        [PHASE_WIDTH-1:0]   phase,
    input  wire        [ENV_WIDTH-1:0]     env,
    output logic signed [SAMPLE_WIDTH-1:0] sample,
    output logic                           sample_valid
);
    `include "quarter_sine.svh"

    logic [QUARTER_SINE_BITS-1:0]        idx;
    logic [SAMPLE_WIDTH-2:0]             mag_q;
    logic                                neg_q;
    logic [ENV_WIDTH-1:0]                level_q;
    logic                                stage1_valid;
    logic [SAMPLE_WIDTH+ENV_WIDTH-2:0]   product;
    logic [SAMPLE_WIDTH-2:0]             scaled;

    // bit 18 selects the falling quarter, where the table is read backwards
    always_comb begin
        idx = phase[PHASE_WIDTH-3 -: QUARTER_SINE_BITS];
        if (phase[PHASE_WIDTH-2])
            idx = ~idx;
    end

    // level is 511 - env, which for a 9 bit field is its complement
    always_ff @(posedge clk) begin
        mag_q   <= QUARTER_SINE[idx];
        neg_q   <= phase[PHASE_WIDTH-1];
        level_q <= ~env;
    end

    always_comb begin
        product = mag_q * level_q;
        scaled  = product[SAMPLE_WIDTH+ENV_WIDTH-2:ENV_WIDTH];
    end

    always_ff @(posedge clk) begin
        if (neg_q)
            sample <= -$signed({1'b0, scaled});
        else
            sample <= $signed({1'b0, scaled});
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage1_valid <= 1'b0;
            sample_valid <= 1'b0;
        end else begin
            stage1_valid <= phase_en;
            sample_valid <= stage1_valid;
        end
    end

endmodule

`default_nettype wire

// ==== source/phase_gen.sv ====
/*
  Phase accumulator. Step = (fnum * mult) << block >> 1, where mult 0
  counts as one half. Register changes are picked up on the next sample_en.
*/
`timescale 1ns/100ps
`default_nettype none

module phase_gen
    import opl3_pkg::*;
(
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    sample_en,
    input  voice_t                 voice,
    output logic [PHASE_WIDTH-1:0] phase,
    output logic                   phase_valid
);
    localparam int SHIFT_WIDTH = FNUM_WIDTH + MULT_WIDTH + 2**BLOCK_WIDTH;

    logic [MULT_WIDTH:0]            mult_x2;
    logic [FNUM_WIDTH+MULT_WIDTH:0] fnum_mult;
    logic [SHIFT_WIDTH-1:0]         shifted;
    logic [PHASE_WIDTH-1:0]         step;

    // mult is doubled so that the half step of mult 0 stays an integer,
    // the extra factor of two comes back out in the final shift
    always_comb begin
        mult_x2   = (voice.mult == '0) ? (MULT_WIDTH+1)'(1) : {voice.mult, 1'b0};
        fnum_mult = voice.fnum * mult_x2;
        shifted   = SHIFT_WIDTH'(fnum_mult) << voice.block;
        step      = PHASE_WIDTH'(shifted >> 2);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase       <= '0;
            phase_valid <= 1'b0;
        end else begin
            phase_valid <= sample_en;
            if (sample_en)
                phase <= voice.key_on ? phase + step : '0;
        end
    end

endmodule

`default_nettype wire

// ==== source/tone_regs.sv ====
/*
  Voice register file behind a four-phase req/ack port. req may come from
  another clock domain; wr must be stable while req is high.
*/
`timescale 1ns/100ps
`default_nettype none

module tone_regs
    import opl3_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    input  wire        req,
    input  reg_write_t wr,
    output logic       ack,
    output voice_t     voice
);
    logic req_meta;
    logic req_sync;

    // ack simply follows the synchronized req one cycle later, and the
    // write is captured on the single cycle where req_sync leads ack
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_meta     <= 1'b0;
            req_sync     <= 1'b0;
            ack          <= 1'b0;
            voice.fnum   <= '0;
            voice.mult   <= MULT_WIDTH'(1);
            voice.block  <= '0;
            voice.env    <= '1;
            voice.key_on <= 1'b0;
        end else begin
            req_meta <= req;
            req_sync <= req_meta;
            ack      <= req_sync;
            if (req_sync && !ack) begin
                case (wr.addr)
                    REG_FNUM:  voice.fnum   <= wr.data[FNUM_WIDTH-1:0];
                    REG_MULT:  voice.mult   <= wr.data[MULT_WIDTH-1:0];
                    REG_BLOCK: voice.block  <= wr.data[BLOCK_WIDTH-1:0];
                    REG_ENV:   voice.env    <= wr.data[ENV_WIDTH-1:0];
                    REG_KEY:   voice.key_on <= wr.data[0];
                    // unknown addresses are dropped but still acknowledged
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/clk_div.sv ====
/*
  Clock-enable divider. The ratio INPUT_CLK_FREQ / OUTPUT_CLK_EN_FREQ is
  truncated to an integer and must be at least 2.
*/
`timescale 1ns/100ps
`default_nettype none

module clk_div #(
    parameter int INPUT_CLK_FREQ     = 12288000,
    parameter int OUTPUT_CLK_EN_FREQ = 48000
) (
    input  wire  clk,
    input  wire  rst_n,
    output logic clk_en
);
    localparam int DIVIDE    = INPUT_CLK_FREQ / OUTPUT_CLK_EN_FREQ;
    localparam int CNT_WIDTH = $clog2(DIVIDE);

    logic [CNT_WIDTH-1:0] count;

    // clk_en is high in the cycle after the counter hits its last value
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count  <= '0;
            clk_en <= 1'b0;
        end else begin
            clk_en <= (count == CNT_WIDTH'(DIVIDE - 1));
            if (count == CNT_WIDTH'(DIVIDE - 1))
                count <= '0;
            else
                count <= count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== source/opl3_pkg.sv ====
/*
  Shared widths and types for the single-voice FM tone slice.
  Attenuation runs linearly from 0 (full level) to 511 (silence).
*/
`default_nettype none

package opl3_pkg;

    localparam int FNUM_WIDTH     = 10;
    localparam int MULT_WIDTH     = 4;
    localparam int BLOCK_WIDTH    = 3;
    localparam int ENV_WIDTH      = 9;
    localparam int PHASE_WIDTH    = 20;
    localparam int SAMPLE_WIDTH   = 16;
    localparam int REG_DATA_WIDTH = 10;

    // register addresses seen on the host write port
    typedef enum logic [2:0] {
        REG_FNUM,
        REG_MULT,
        REG_BLOCK,
        REG_ENV,
        REG_KEY
    } reg_addr_t;

    // one register write, held stable by the host while req is high
    typedef struct packed {
        reg_addr_t                 addr;
        logic [REG_DATA_WIDTH-1:0] data;
    } reg_write_t;

    typedef struct packed {
        logic [FNUM_WIDTH-1:0]  fnum;
        logic [MULT_WIDTH-1:0]  mult;
        logic [BLOCK_WIDTH-1:0] block;
        logic [ENV_WIDTH-1:0]   env;
        logic                   key_on;
    } voice_t;

endpackage

`default_nettype wire

// ==== source/quarter_sine.svh ====
/*
  Quarter-wave sine magnitudes, entry i = round(32767 * sin(i * pi / 128)).
  Entry 0 is zero so the output crosses zero at phase 0 and at the half.
  Included inside a module scope that has opl3_pkg imported.
*/
`ifndef QUARTER_SINE_SVH
`define QUARTER_SINE_SVH

localparam int QUARTER_SINE_BITS = 6;

localparam logic [SAMPLE_WIDTH-2:0] QUARTER_SINE [2**QUARTER_SINE_BITS] = '{
    15'd0,
    15'd804,
    15'd1608,
    15'd2410,
    15'd3212,
    15'd4011,
    15'd4808,
    15'd5602,
    15'd6393,
    15'd7179,
    15'd7962,
    15'd8739,
    15'd9512,
    15'd10278,
    15'd11039,
    15'd11793,
    15'd12539,
    15'd13278,
    15'd14010,
    15'd14732,
    15'd15446,
    15'd16151,
    15'd16846,
    15'd17530,
    15'd18204,
    15'd18867,
    15'd19519,
    15'd20159,
    15'd20787,
    15'd21402,
    15'd22005,
    15'd22594,
    15'd23170,
    15'd23731,
    15'd24279,
    15'd24811,
    15'd25329,
    15'd25832,
    15'd26319,
    15'd26790,
    15'd27245,
    15'd27683,
    15'd28105,
    15'd28510,
    15'd28898,
    15'd29268,
    15'd29621,
    15'd29956,
    15'd30273,
    15'd30571,
    15'd30852,
    15'd31113,
    15'd31356,
    15'd31580,
    15'd31785,
    15'd31971,
    15'd32137,
    15'd32285,
    15'd32412,
    15'd32521,
    15'd32609,
    15'd32678,
    15'd32728,
    15'd32757
};

`endif
